/* build.f */
hw/mips_pkg.sv
hw/fetch_unit.sv
hw/decode_control.sv
hw/reg_file.sv
hw/alu.sv
hw/mem_writeback.sv
hw/mips_core.sv
testbench/mips_checker.sv
testbench/tb_mips.sv

/* hw/alu.sv */
// Integer ALU for the core.
// Add, subtract, and, or and signed set-less-than on two 32-bit operands.
// zero flags an all-zero result and drives the beq decision.

`timescale 1ns/1ns

module alu
    import mips_pkg::*;
(
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_t         op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // signed compare gives 1 or 0
            ALU_SLT: result = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* hw/decode_control.sv */
// Instruction decoder and main control.
// Splits the fetched word into register indices and a sign-extended
// immediate, and turns opcode plus funct into control levels and one alu_op.

`timescale 1ns/1ns

module decode_control
    import mips_pkg::*;
(
    input  instr_t                instr,
    output logic [REG_ADDR_W-1:0] rs_addr,
    output logic [REG_ADDR_W-1:0] rt_addr,
    output logic [REG_ADDR_W-1:0] wr_addr,
    output logic [XLEN-1:0]       imm_ext,
    output logic [25:0]           target26,
    output logic                  reg_write,
    output logic                  alu_src,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  mem_to_reg,
    output logic                  branch,
    output logic                  jump,
    output alu_op_t               alu_op
);

    logic    fn_valid;
    alu_op_t fn_op;

    // ==================================================
    // field extraction
    // ==================================================
    assign rs_addr  = instr.r.rs;
    assign rt_addr  = instr.r.rt;
    // R-type writes rd, I-type writes rt
    assign wr_addr  = (instr.r.op == OP_RTYPE) ? instr.r.rd : instr.i.rt;
    assign imm_ext  = {{(XLEN-16){instr.i.imm16[15]}}, instr.i.imm16};
    assign target26 = instr.j.target26;

    // funct decode for R-type
    always_comb begin
        fn_valid = 1'b1;
        case (instr.r.funct)
            FN_ADD:  fn_op = ALU_ADD;
            FN_SUB:  fn_op = ALU_SUB;
            FN_AND:  fn_op = ALU_AND;
            FN_OR:   fn_op = ALU_OR;
            FN_SLT:  fn_op = ALU_SLT;
            default: begin
                fn_op    = ALU_ADD;
                fn_valid = 1'b0;
            end
        endcase
    end

    // ==================================================
    // main control
    // ==================================================
    always_comb begin
        // defaults describe a nop
        reg_write  = 1'b0;
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        alu_op     = ALU_ADD;
        case (instr.r.op)
            OP_RTYPE: begin
                reg_write = fn_valid;
                alu_op    = fn_op;
            end
            OP_LW: begin
                reg_write  = 1'b1;
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            OP_BEQ: begin
                branch = 1'b1;
                alu_op = ALU_SUB;
            end
            OP_ADDI: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            OP_J:    jump = 1'b1;
            default: ;
        endcase
    end

endmodule

/* hw/fetch_unit.sv */
// Program counter and next-pc selection.
// Loads one next pc per clock: jump target, taken branch target or pc plus 4.
// Reset forces the pc to address 0.

`timescale 1ns/1ns

module fetch_unit
    import mips_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            branch,
    input  logic            jump,
    input  logic            zero,
    input  logic [XLEN-1:0] imm_ext,
    input  logic [25:0]     target26,
    output logic [XLEN-1:0] pc
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] br_target;
    logic [XLEN-1:0] j_target;
    logic [XLEN-1:0] pc_next;

    assign pc_plus4  = pc + XLEN'(4);
    // the offset counts words so the immediate moves left by two
    assign br_target = pc_plus4 + {imm_ext[XLEN-3:0], 2'b00};
    // region bits come from pc plus 4
    assign j_target  = {pc_plus4[XLEN-1:XLEN-4], target26, 2'b00};

    // jump wins over branch
    always_comb begin
        if (jump) begin
            pc_next = j_target;
        end else if (branch && zero) begin
            pc_next = br_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

/* hw/mem_writeback.sv */
// Data-memory strobes and register writeback.
// Drives the active-low SRAM controls for loads and stores, the word
// address and store data, and picks the value written to the register file.

`timescale 1ns/1ns

module mem_writeback
    import mips_pkg::*;
(
    input  logic                   rst_n,
    input  logic                   mem_read,
    input  logic                   mem_write,
    input  logic                   mem_to_reg,
    input  logic                   reg_write,
    input  logic [XLEN-1:0]        alu_result,
    input  logic [XLEN-1:0]        rt_data,
    input  logic [XLEN-1:0]        dmem_rdata,
    input  logic [REG_ADDR_W-1:0]  wr_addr,
    output logic                   dmem_cen_n,
    output logic                   dmem_wen_n,
    output logic                   dmem_oen_n,
    output logic [DMEM_ADDR_W-1:0] dmem_addr,
    output logic [XLEN-1:0]        dmem_wdata,
    output logic                   rf_wr_en,
    output logic [REG_ADDR_W-1:0]  rf_wr_addr,
    output logic [XLEN-1:0]        rf_wr_data
);

    assign dmem_cen_n = rst_n | ~(mem_read | mem_write);
    assign dmem_wen_n = rst_n | ~mem_write;
    assign dmem_oen_n = 1'b0;
    assign dmem_addr  = alu_result[DMEM_ADDR_W+1:2];
    assign dmem_wdata = rt_data;

    assign rf_wr_en   = reg_write & ~rst_n;
    assign rf_wr_addr = wr_addr;
    assign rf_wr_data = mem_to_reg ? dmem_rdata : alu_result;

endmodule

/* hw/mips_core.sv */
// Top level of the single-cycle MIPS core.
// Connects fetch, decode, register file, ALU and the memory/writeback stage.
// Instruction and data memories sit outside and answer in the same cycle.

`timescale 1ns/1ns

module mips_core
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  instr_t                 instr,
    input  logic [XLEN-1:0]        dmem_rdata,
    output logic [XLEN-1:0]        imem_addr,
    output logic                   dmem_cen_n,
    output logic                   dmem_wen_n,
    output logic                   dmem_oen_n,
    output logic [DMEM_ADDR_W-1:0] dmem_addr,
    output logic [XLEN-1:0]        dmem_wdata,
    output logic                   rf_wr_en,
    output logic [REG_ADDR_W-1:0]  rf_wr_addr,
    output logic [XLEN-1:0]        rf_wr_data
);

    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       imm_ext;
    logic [25:0]           target26;
    logic                  reg_write;
    logic                  alu_src;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;
    logic                  branch;
    logic                  jump;
    alu_op_t               alu_op;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_result;
    logic                  zero;

    // ==================================================
    // input side
    // ==================================================
    // the pc doubles as the instruction address
    fetch_unit fetch_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .branch   (branch),
        .jump     (jump),
        .zero     (zero),
        .imm_ext  (imm_ext),
        .target26 (target26),
        .pc       (imem_addr)
    );

    decode_control decode_i (
        .instr      (instr),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .wr_addr    (wr_addr),
        .imm_ext    (imm_ext),
        .target26   (target26),
        .reg_write  (reg_write),
        .alu_src    (alu_src),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .branch     (branch),
        .jump       (jump),
        .alu_op     (alu_op)
    );

    // ==================================================
    // processing
    // ==================================================
    // register write uses the reset-gated enable from writeback
    reg_file rf_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (rf_wr_en),
        .wr_addr (rf_wr_addr),
        .wr_data (rf_wr_data),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // immediate for lw, sw and addi
    assign alu_b = alu_src ? imm_ext : rt_data;

    alu alu_i (
        .a      (rs_data),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    // ==================================================
    // output side
    // ==================================================
    mem_writeback mwb_i (
        .rst_n      (rst_n),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .alu_result (alu_result),
        .rt_data    (rt_data),
        .dmem_rdata (dmem_rdata),
        .wr_addr    (wr_addr),
        .dmem_cen_n (dmem_cen_n),
        .dmem_wen_n (dmem_wen_n),
        .dmem_oen_n (dmem_oen_n),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .rf_wr_en   (rf_wr_en),
        .rf_wr_addr (rf_wr_addr),
        .rf_wr_data (rf_wr_data)
    );

endmodule

/* hw/mips_pkg.sv */
// Shared definitions for the single-cycle MIPS core.
// Holds the sizes, opcode and funct encodings, the ALU operation codes
// and the instruction word union. Modules pull it in with a wildcard import.

package mips_pkg;

    // ==================================================
    // sizes
    // ==================================================
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    // 128 words of data memory
    localparam int DMEM_ADDR_W = 7;

    // ==================================================
    // opcodes and funct codes
    // ==================================================
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_J     = 6'b000010;

    localparam logic [5:0] FN_ADD   = 6'b100000;
    localparam logic [5:0] FN_SUB   = 6'b100010;
    localparam logic [5:0] FN_AND   = 6'b100100;
    localparam logic [5:0] FN_OR    = 6'b100101;
    localparam logic [5:0] FN_SLT   = 6'b101010;

    // alu operation codes in the classic MIPS control encoding
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } alu_op_t;

    // ==================================================
    // instruction word, one view per format
    // ==================================================
    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

endpackage

/* hw/reg_file.sv */
// General-purpose register file, 31 writable registers.
// Two combinational read ports and one write port on the rising edge.
// Register 0 always reads as zero and ignores writes.

`timescale 1ns/1ns

module reg_file
    import mips_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_addr,
    input  logic [XLEN-1:0]       wr_data,
    input  logic [REG_ADDR_W-1:0] rs_addr,
    input  logic [REG_ADDR_W-1:0] rt_addr,
    output logic [XLEN-1:0]       rs_data,
    output logic [XLEN-1:0]       rt_data
);

    // no storage behind index 0
    logic [XLEN-1:0] regs [1:31];

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compiles the MIPS core and its testbench with Verilator and runs the simulation.
# The run passes only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_mips -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    echo "run passed"
    exit 0
fi
echo "run failed"
exit 1

/* testbench/mips_checker.sv */
// Result checker for the MIPS core testbench.
// Samples the DUT ports at the falling clock edge, where they are stable for
// the coming rising edge, and compares them with the expected record.
// Counts mismatches and checked cycles for the testbench top.

`timescale 1ns/1ns

module mips_checker
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [XLEN-1:0]        pc,
    input  logic                   dmem_cen_n,
    input  logic                   dmem_wen_n,
    input  logic                   dmem_oen_n,
    input  logic [DMEM_ADDR_W-1:0] dmem_addr,
    input  logic [XLEN-1:0]        dmem_wdata,
    input  logic                   rf_wr_en,
    input  logic [REG_ADDR_W-1:0]  rf_wr_addr,
    input  logic [XLEN-1:0]        rf_wr_data,
    input  logic                   exp_valid,
    input  logic [XLEN-1:0]        exp_pc,
    input  logic                   exp_wr_en,
    input  logic [REG_ADDR_W-1:0]  exp_wr_addr,
    input  logic [XLEN-1:0]        exp_wr_data,
    input  logic                   exp_st,
    input  logic [DMEM_ADDR_W-1:0] exp_st_addr,
    input  logic [XLEN-1:0]        exp_st_data,
    output int                     err_count,
    output int                     check_count
);

    task automatic report_mismatch(input string msg);
        err_count++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    // ==================================================
    // per-cycle compare against the expected record
    // ==================================================
    task automatic compare_cycle();
        if (pc !== exp_pc) begin
            report_mismatch($sformatf("pc is %h, expected %h", pc, exp_pc));
        end
        if (dmem_oen_n !== 1'b0) begin
            report_mismatch($sformatf("pc %h: dmem_oen_n is not held low", exp_pc));
        end
        if (exp_wr_en) begin
            if (rf_wr_en !== 1'b1 || rf_wr_addr !== exp_wr_addr || rf_wr_data !== exp_wr_data) begin
                report_mismatch($sformatf("pc %h: register write %b r%0d = %h, expected r%0d = %h",
                    exp_pc, rf_wr_en, rf_wr_addr, rf_wr_data, exp_wr_addr, exp_wr_data));
            end
        end else if (rf_wr_en !== 1'b0) begin
            report_mismatch($sformatf("pc %h: unexpected register write", exp_pc));
        end
        if (exp_st) begin
            if (dmem_cen_n !== 1'b0 || dmem_wen_n !== 1'b0) begin
                report_mismatch($sformatf("pc %h: store strobes not both low", exp_pc));
            end
            if (dmem_addr !== exp_st_addr || dmem_wdata !== exp_st_data) begin
                report_mismatch($sformatf("pc %h: store [%h] = %h, expected [%h] = %h",
                    exp_pc, dmem_addr, dmem_wdata, exp_st_addr, exp_st_data));
            end
        end else if (dmem_cen_n !== 1'b1 && dmem_wen_n !== 1'b1) begin
            report_mismatch($sformatf("pc %h: unexpected data memory write", exp_pc));
        end
    endtask

    initial begin
        err_count   = 0;
        check_count = 0;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            // reset holds off all writes
            if (rf_wr_en !== 1'b0) begin
                report_mismatch("rf_wr_en is not low during reset");
            end
            if (dmem_cen_n !== 1'b1 || dmem_wen_n !== 1'b1) begin
                report_mismatch("data strobes are not high during reset");
            end
        end else if (exp_valid) begin
            compare_cycle();
            check_count++;
        end
    end

endmodule

/* testbench/mips_golden.txt */
# T name cycles | I byte_addr word | D word_addr word (hex; unlisted code words are nops)
# E pc wr_en wr_addr wr_data store store_addr store_data, all hex, one line per cycle
T reset 2
E 00000000 0 00 00000000 0 00 00000000
E 00000004 0 00 00000000 0 00 00000000
T rtype_alu 11
I 00000004 2001fff9
I 00000008 20020005
I 0000000c 00221820
I 00000010 00412022
I 00000014 00222824
I 00000018 00223025
I 0000001c 0022382a
I 00000020 0041402a
I 00000024 00220020
I 00000028 00024820
E 00000000 0 00 00000000 0 00 00000000
E 00000004 1 01 fffffff9 0 00 00000000
E 00000008 1 02 00000005 0 00 00000000
E 0000000c 1 03 fffffffe 0 00 00000000
E 00000010 1 04 0000000c 0 00 00000000
E 00000014 1 05 00000001 0 00 00000000
E 00000018 1 06 fffffffd 0 00 00000000
E 0000001c 1 07 00000001 0 00 00000000
E 00000020 1 08 00000000 0 00 00000000
E 00000024 1 00 fffffffe 0 00 00000000
E 00000028 1 09 00000005 0 00 00000000
T load_store 5
D 00000010 13572468
I 00000004 8c010040
I 00000008 20020024
I 0000000c ac410008
I 00000010 8c430008
E 00000000 0 00 00000000 0 00 00000000
E 00000004 1 01 13572468 0 00 00000000
E 00000008 1 02 00000024 0 00 00000000
E 0000000c 0 00 00000000 1 0b 13572468
E 00000010 1 03 13572468 0 00 00000000
T branch 10
I 00000004 20010002
I 00000008 10200005
I 0000000c 10000002
I 00000018 2021ffff
I 0000001c 10200001
I 00000020 1000fffd
I 00000024 20020007
E 00000000 0 00 00000000 0 00 00000000
E 00000004 1 01 00000002 0 00 00000000
E 00000008 0 00 00000000 0 00 00000000
E 0000000c 0 00 00000000 0 00 00000000
E 00000018 1 01 00000001 0 00 00000000
E 0000001c 0 00 00000000 0 00 00000000
E 00000020 0 00 00000000 0 00 00000000
E 00000018 1 01 00000000 0 00 00000000
E 0000001c 0 00 00000000 0 00 00000000
E 00000024 1 02 00000007 0 00 00000000
T jump 5
I 00000004 08000010
I 00000040 20010001
I 00000044 08000002
I 00000008 20020002
E 00000000 0 00 00000000 0 00 00000000
E 00000004 0 00 00000000 0 00 00000000
E 00000040 1 01 00000001 0 00 00000000
E 00000044 0 00 00000000 0 00 00000000
E 00000008 1 02 00000002 0 00 00000000

/* testbench/tb_mips.sv */
// Testbench for the single-cycle MIPS core.
// Reads programs, initial data and expected per-cycle results from the
// golden file, runs each test from reset and lets mips_checker compare.
// Run from the project root so that the golden file path resolves.

`timescale 1ns/1ns

module tb_mips
    import mips_pkg::*;
();

    logic                   clk;
    logic                   rst_n;
    instr_t                 instr;
    logic [XLEN-1:0]        dmem_rdata;
    logic [XLEN-1:0]        imem_addr;
    logic                   dmem_cen_n;
    logic                   dmem_wen_n;
    logic                   dmem_oen_n;
    logic [DMEM_ADDR_W-1:0] dmem_addr;
    logic [XLEN-1:0]        dmem_wdata;
    logic                   rf_wr_en;
    logic [REG_ADDR_W-1:0]  rf_wr_addr;
    logic [XLEN-1:0]        rf_wr_data;

    // expected record of the current cycle
    logic                   exp_valid;
    logic [XLEN-1:0]        exp_pc;
    logic                   exp_wr_en;
    logic [REG_ADDR_W-1:0]  exp_wr_addr;
    logic [XLEN-1:0]        exp_wr_data;
    logic                   exp_st;
    logic [DMEM_ADDR_W-1:0] exp_st_addr;
    logic [XLEN-1:0]        exp_st_data;
    int                     err_count;
    int                     check_count;

    // memory models
    logic [XLEN-1:0] imem [0:127];
    logic [XLEN-1:0] dmem [0:(1<<DMEM_ADDR_W)-1];

    // golden records of the test being loaded
    logic [XLEN-1:0]        q_pc [$];
    logic                   q_wr_en [$];
    logic [REG_ADDR_W-1:0]  q_wr_addr [$];
    logic [XLEN-1:0]        q_wr_data [$];
    logic                   q_st [$];
    logic [DMEM_ADDR_W-1:0] q_st_addr [$];
    logic [XLEN-1:0]        q_st_data [$];

    string test_name;
    int    n_cycles;
    int    n_pass;
    int    n_fail;
    bit    tb_fail;
    bit    timed_out;

    always #50 clk = ~clk;

    assign instr      = imem[imem_addr[8:2]];
    assign dmem_rdata = (!dmem_cen_n && dmem_wen_n && !dmem_oen_n) ? dmem[dmem_addr] : '0;

    always @(posedge clk) begin
        if (!dmem_cen_n && !dmem_wen_n) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    mips_core dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_cen_n (dmem_cen_n),
        .dmem_wen_n (dmem_wen_n),
        .dmem_oen_n (dmem_oen_n),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .rf_wr_en   (rf_wr_en),
        .rf_wr_addr (rf_wr_addr),
        .rf_wr_data (rf_wr_data)
    );

    mips_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (imem_addr),
        .dmem_cen_n  (dmem_cen_n),
        .dmem_wen_n  (dmem_wen_n),
        .dmem_oen_n  (dmem_oen_n),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .rf_wr_en    (rf_wr_en),
        .rf_wr_addr  (rf_wr_addr),
        .rf_wr_data  (rf_wr_data),
        .exp_valid   (exp_valid),
        .exp_pc      (exp_pc),
        .exp_wr_en   (exp_wr_en),
        .exp_wr_addr (exp_wr_addr),
        .exp_wr_data (exp_wr_data),
        .exp_st      (exp_st),
        .exp_st_addr (exp_st_addr),
        .exp_st_data (exp_st_data),
        .err_count   (err_count),
        .check_count (check_count)
    );

    // ==================================================
    // test sequencing
    // ==================================================
    // enter reset, then refill both memories
    task automatic start_test();
        rst_n     = 1'b1;
        exp_valid = 1'b0;
        q_pc.delete();
        q_wr_en.delete();
        q_wr_addr.delete();
        q_wr_data.delete();
        q_st.delete();
        q_st_addr.delete();
        q_st_data.delete();
        for (int a = 0; a < 128; a++) begin
            // an invalid funct makes unused words act as nops
            imem[a] = {6'h00, 20'(a), 6'h3f};
            dmem[a] = $urandom;
        end
    endtask

    task automatic run_test();
        int errs_before;
        int target;
        int guard;
        bit test_bad;
        errs_before = err_count;
        target      = check_count + q_pc.size();
        test_bad    = 1'b0;
        if (q_pc.size() != n_cycles) begin
            $display("test %s: golden file has %0d expected records for %0d cycles",
                test_name, q_pc.size(), n_cycles);
            test_bad = 1'b1;
        end
        for (int r = 0; r < 2; r++) begin
            @(posedge clk);
            #5;
        end
        rst_n = 1'b0;
        for (int k = 0; k < q_pc.size(); k++) begin
            exp_pc      = q_pc[k];
            exp_wr_en   = q_wr_en[k];
            exp_wr_addr = q_wr_addr[k];
            exp_wr_data = q_wr_data[k];
            exp_st      = q_st[k];
            exp_st_addr = q_st_addr[k];
            exp_st_data = q_st_data[k];
            exp_valid   = 1'b1;
            @(posedge clk);
            #5;
        end
        exp_valid = 1'b0;
        // wait for the checker to have seen every cycle
        guard = 0;
        while (check_count < target && guard < 200) begin
            @(posedge clk);
            #5;
            guard++;
        end
        if (check_count < target) begin
            $display("timeout: checker did not finish test %s within 200 cycles", test_name);
            timed_out = 1'b1;
        end
        if (err_count == errs_before && !test_bad && !timed_out) begin
            n_pass++;
            $display("test %s ok, %0d cycles checked", test_name, q_pc.size());
        end else begin
            n_fail++;
            $display("test %s failed, %0d mismatches", test_name, err_count - errs_before);
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // ==================================================
    // golden file parsing and final verdict
    // ==================================================
    initial begin
        int          fd;
        int          code;
        bit          have_test;
        string       tag;
        logic [31:0] v_a;
        logic [31:0] v_w;
        logic [31:0] v_pc;
        logic [31:0] v_en;
        logic [31:0] v_wa;
        logic [31:0] v_wd;
        logic [31:0] v_st;
        logic [31:0] v_sa;
        logic [31:0] v_sd;
        clk         = 1'b0;
        rst_n       = 1'b1;
        exp_valid   = 1'b0;
        exp_pc      = '0;
        exp_wr_en   = 1'b0;
        exp_wr_addr = '0;
        exp_wr_data = '0;
        exp_st      = 1'b0;
        exp_st_addr = '0;
        exp_st_data = '0;
        n_cycles    = 0;
        n_pass      = 0;
        n_fail      = 0;
        tb_fail     = 1'b0;
        timed_out   = 1'b0;
        have_test   = 1'b0;
        void'($urandom(32'h6205_289e));
        fd = $fopen("testbench/mips_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open golden file testbench/mips_golden.txt");
            tb_fail = 1'b1;
        end else begin
            code = $fscanf(fd, " %s", tag);
            while (code == 1 && !timed_out) begin
                if (tag == "T") begin
                    if (have_test) begin
                        run_test();
                    end
                    code = $fscanf(fd, " %s %d", test_name, n_cycles);
                    start_test();
                    have_test = 1'b1;
                end else if (tag == "I") begin
                    code = $fscanf(fd, " %h %h", v_a, v_w);
                    imem[v_a[8:2]] = v_w;
                end else if (tag == "D") begin
                    code = $fscanf(fd, " %h %h", v_a, v_w);
                    dmem[v_a[DMEM_ADDR_W-1:0]] = v_w;
                end else if (tag == "E") begin
                    code = $fscanf(fd, " %h %h %h %h %h %h %h",
                        v_pc, v_en, v_wa, v_wd, v_st, v_sa, v_sd);
                    q_pc.push_back(v_pc);
                    q_wr_en.push_back(v_en[0]);
                    q_wr_addr.push_back(v_wa[REG_ADDR_W-1:0]);
                    q_wr_data.push_back(v_wd);
                    q_st.push_back(v_st[0]);
                    q_st_addr.push_back(v_sa[DMEM_ADDR_W-1:0]);
                    q_st_data.push_back(v_sd);
                end else if (tag[0] == "#") begin
                    skip_line(fd);
                end else begin
                    $display("unknown record %s in golden file", tag);
                    tb_fail = 1'b1;
                end
                code = $fscanf(fd, " %s", tag);
            end
            if (have_test && !timed_out) begin
                run_test();
            end
            $fclose(fd);
        end
        if (timed_out) begin
            $display("run stopped after a timeout");
        end
        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0 && !tb_fail && !timed_out && err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
